// File: hdl/mipsPkg.sv
package mipsPkg;

    // primary opcodes, instruction bits 31:26
    localparam logic [5:0] opSpecial = 6'b000000;  // r-type, decoded by funct
    localparam logic [5:0] opRegimm  = 6'b000001;  // decoded by rt
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opAndi    = 6'b001100;  // zero-extended imm
    localparam logic [5:0] opOri     = 6'b001101;  // zero-extended imm
    localparam logic [5:0] opXori    = 6'b001110;  // zero-extended imm
    localparam logic [5:0] opLui     = 6'b001111;

    // special funct codes, bits 5:0
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnSra  = 6'b000011;
    localparam logic [5:0] fnSllv = 6'b000100;  // amount from rs
    localparam logic [5:0] fnSrlv = 6'b000110;
    localparam logic [5:0] fnSrav = 6'b000111;
    localparam logic [5:0] fnJalr = 6'b001001;  // link into rd
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnNor  = 6'b100111;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    // regimm rt codes
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    localparam logic [4:0]  linkRegister    = 5'd31;  // ra
    localparam logic [4:0]  stackRegister   = 5'd29;  // sp
    localparam logic [31:0] stackResetValue = 32'h7FFF;  // stack top

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOpCode;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat;

    // same 32 bits, read as r-format or i-format
    typedef union packed {
        rFormat rView;
        iFormat iView;
    } instrWord;

    typedef struct packed {
        aluOpCode aluOp;
        logic     useImmediate;       // second operand is imm
        logic     zeroExtend;         // logical immediates
        logic     useShamt;           // fixed shift amount
        logic     writesRd;
        logic     writesRt;
        logic     linkAlways;         // jal
        logic     linkRd;             // jalr
        logic     linkIfNonNegative;  // bgezal
        logic     linkIfNegative;     // bltzal
    } controlBundle;

endpackage

// File: hdl/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import mipsPkg::*; (
    input  instrWord     instruction,
    output controlBundle control
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rtCode;

    assign opcode = instruction.rView.opcode;
    assign funct  = instruction.rView.funct;
    assign rtCode = instruction.iView.rt;  // regimm sub-opcode

    always_comb begin
        control = '0;  // unknown encodings write nothing
        case (opcode)
            opSpecial: begin
                control.writesRd = 1'b1;  // cleared again below if funct unknown
                case (funct)
                    fnSll: begin
                        control.aluOp    = aluSll;
                        control.useShamt = 1'b1;
                    end
                    fnSrl: begin
                        control.aluOp    = aluSrl;
                        control.useShamt = 1'b1;
                    end
                    fnSra: begin
                        control.aluOp    = aluSra;
                        control.useShamt = 1'b1;
                    end
                    fnSllv:         control.aluOp = aluSll;  // amount from rs
                    fnSrlv:         control.aluOp = aluSrl;
                    fnSrav:         control.aluOp = aluSra;
                    fnJalr:         control.linkRd = 1'b1;   // pc+4 into rd
                    fnAdd, fnAddu:  control.aluOp = aluAdd;  // no overflow trap
                    fnSub, fnSubu:  control.aluOp = aluSub;
                    fnAnd:          control.aluOp = aluAnd;
                    fnOr:           control.aluOp = aluOr;
                    fnXor:          control.aluOp = aluXor;
                    fnNor:          control.aluOp = aluNor;
                    fnSlt:          control.aluOp = aluSlt;
                    fnSltu:         control.aluOp = aluSltu;
                    default:        control = '0;
                endcase
            end
            opRegimm: begin
                if (rtCode == rtBgezal) control.linkIfNonNegative = 1'b1;
                else if (rtCode == rtBltzal) control.linkIfNegative = 1'b1;
                // other regimm branches have no writeback here
            end
            opJal: control.linkAlways = 1'b1;
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                control.writesRt     = 1'b1;  // i-type dest is rt
                control.useImmediate = 1'b1;
                case (opcode)
                    opSlti:  control.aluOp = aluSlt;
                    opSltiu: control.aluOp = aluSltu;  // sign-extended, unsigned compare
                    opAndi:  control.aluOp = aluAnd;
                    opOri:   control.aluOp = aluOr;
                    opXori:  control.aluOp = aluXor;
                    opLui:   control.aluOp = aluLui;
                    default: control.aluOp = aluAdd;   // addi, addiu
                endcase
                control.zeroExtend = (opcode == opAndi) || (opcode == opOri) ||
                                     (opcode == opXori);
            end
            default: control = '0;
        endcase
    end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic [4:0]  readAddressA,  // rs
    input  logic [4:0]  readAddressB,  // rt
    input  logic [4:0]  writeAddress,
    input  logic        writeEnable,   // already excludes r0
    input  logic [31:0] writeData,
    output logic [31:0] operandA,
    output logic [31:0] operandB
);

    logic [31:0] registers [32];

    // async read, new value visible the cycle after a write
    assign operandA = registers[readAddressA];
    assign operandB = registers[readAddressB];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                if (i == int'(stackRegister)) begin
                    registers[i] <= stackResetValue;  // sp at stack top
                end else begin
                    registers[i] <= 32'(i);  // reset image is the index
                end
            end
        end else if (writeEnable) begin
            registers[writeAddress] <= writeData;
        end
    end

endmodule

// File: hdl/operandDecode.sv
`timescale 1ns/1ps

module operandDecode import mipsPkg::*; (
    input  logic         issue,
    input  instrWord     instruction,
    input  controlBundle control,
    input  logic [31:0]  pcPlus4,
    input  logic [31:0]  aluResult,
    input  logic         negative,      // rs bit 31
    output logic [4:0]   readAddressA,
    output logic [4:0]   readAddressB,
    output logic [4:0]   writeAddress,
    output logic [31:0]  immediate,
    output logic         writeEnable,
    output logic [31:0]  writeData
);

    logic [15:0] rawImmediate;
    logic [4:0]  rdField;
    logic [4:0]  rtField;
    logic        linkTaken;     // r31 link that fires this cycle
    logic        anyLink;       // data is pc+4
    logic        wantsWrite;

    assign readAddressA = instruction.rView.rs;
    assign rtField      = instruction.rView.rt;
    assign readAddressB = rtField;
    assign rdField      = instruction.rView.rd;
    assign rawImmediate = instruction.iView.imm;

    // logical immediates zero-extend, the rest sign-extend
    assign immediate = control.zeroExtend ? {16'h0000, rawImmediate}
                                          : {{16{rawImmediate[15]}}, rawImmediate};

    // regimm links depend on the sign of rs
    assign linkTaken = control.linkAlways ||
                       (control.linkIfNonNegative && !negative) ||
                       (control.linkIfNegative && negative);
    assign anyLink   = linkTaken || control.linkRd;

    always_comb begin
        if (linkTaken) begin
            writeAddress = linkRegister;  // jal, bgezal, bltzal
        end else if (control.writesRd) begin
            writeAddress = rdField;       // r-type and jalr
        end else if (control.writesRt) begin
            writeAddress = rtField;       // i-type
        end else begin
            writeAddress = 5'd0;          // no destination
        end
    end

    assign writeData = anyLink ? pcPlus4 : aluResult;

    // untaken regimm link falls through with no write flag set
    assign wantsWrite = linkTaken || control.writesRd || control.writesRt;

    // r0 is never written, the register file relies on this
    assign writeEnable = issue && wantsWrite && (writeAddress != 5'd0);

endmodule

// File: hdl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; (
    input  controlBundle control,
    input  logic [31:0]  operandA,    // rs value
    input  logic [31:0]  operandB,    // rt value
    input  logic [31:0]  immediate,   // already extended
    input  logic [4:0]   shamt,
    output logic [31:0]  aluResult,
    output logic         negative
);

    logic [31:0] secondOperand;
    logic [4:0]  shiftAmount;
    logic        signedLess;
    logic        unsignedLess;

    assign secondOperand = control.useImmediate ? immediate : operandB;

    // sll/srl/sra take shamt, the v forms take rs low bits
    assign shiftAmount = control.useShamt ? shamt : operandA[4:0];

    assign signedLess   = $signed(operandA) < $signed(secondOperand);
    assign unsignedLess = operandA < secondOperand;

    always_comb begin
        case (control.aluOp)
            aluAdd:  aluResult = operandA + secondOperand;  // wraps, no trap
            aluSub:  aluResult = operandA - secondOperand;
            aluAnd:  aluResult = operandA & secondOperand;
            aluOr:   aluResult = operandA | secondOperand;
            aluXor:  aluResult = operandA ^ secondOperand;
            aluNor:  aluResult = ~(operandA | secondOperand);
            aluSlt:  aluResult = {31'd0, signedLess};
            aluSltu: aluResult = {31'd0, unsignedLess};
            aluSll:  aluResult = operandB << shiftAmount;   // shifts act on rt
            aluSrl:  aluResult = operandB >> shiftAmount;
            aluSra:  aluResult = $unsigned($signed(operandB) >>> shiftAmount);
            aluLui:  aluResult = {immediate[15:0], 16'h0000};
            default: aluResult = 32'd0;
        endcase
    end

    // sign of rs for bgezal and bltzal
    assign negative = operandA[31];

endmodule

// File: hdl/decodeExecuteTop.sv
`timescale 1ns/1ps

module decodeExecuteTop import mipsPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue,        // level-qualified from fetch
    input  instrWord    instruction,
    input  logic [31:0] pcPlus4,
    output logic        commitValid,
    output logic [4:0]  commitAddress,
    output logic [31:0] commitData
);

    controlBundle control;
    logic [4:0]   readAddressA;
    logic [4:0]   readAddressB;
    logic [4:0]   writeAddress;
    logic [31:0]  operandA;
    logic [31:0]  operandB;
    logic [31:0]  immediate;
    logic [31:0]  aluResult;
    logic [31:0]  writeData;
    logic         writeEnable;
    logic         negative;

    controlDecoder decoder (
        .instruction (instruction),
        .control     (control)
    );

    registerFile regs (
        .clock        (clock),
        .reset        (reset),
        .readAddressA (readAddressA),
        .readAddressB (readAddressB),
        .writeAddress (writeAddress),
        .writeEnable  (writeEnable),
        .writeData    (writeData),
        .operandA     (operandA),
        .operandB     (operandB)
    );

    operandDecode operands (
        .issue        (issue),
        .instruction  (instruction),
        .control      (control),
        .pcPlus4      (pcPlus4),
        .aluResult    (aluResult),
        .negative     (negative),
        .readAddressA (readAddressA),
        .readAddressB (readAddressB),
        .writeAddress (writeAddress),
        .immediate    (immediate),
        .writeEnable  (writeEnable),
        .writeData    (writeData)
    );

    executeUnit execute (
        .control   (control),
        .operandA  (operandA),
        .operandB  (operandB),
        .immediate (immediate),
        .shamt     (instruction.rView.shamt),
        .aluResult (aluResult),
        .negative  (negative)
    );

    // commit port mirrors the register file write
    assign commitValid   = writeEnable;
    assign commitAddress = writeAddress;
    assign commitData    = writeData;

endmodule

// File: verif/decodeExecute_properties.sv
`timescale 1ns/1ps

module decodeExecute_properties (
    input logic       clock,
    input logic       reset,
    input logic       issue,
    input logic       commitValid,
    input logic [4:0] commitAddress
);

    commitNeedsIssue: assert property (@(posedge clock) disable iff (reset)
        commitValid |-> issue)
        else $error("commit without issue");  // no spontaneous writes

    commitNotZero: assert property (@(posedge clock) disable iff (reset)
        commitValid |-> commitAddress != 5'd0)
        else $error("commit to r0");

    quietInReset: assert property (@(posedge clock) reset |-> !commitValid)
        else $error("commit during reset");

endmodule

bind decodeExecuteTop decodeExecute_properties commitProperties (
    .clock         (clock),
    .reset         (reset),
    .issue         (issue),
    .commitValid   (commitValid),
    .commitAddress (commitAddress)
);

// File: verif/decodeExecuteChecker.sv
`timescale 1ns/1ps

module decodeExecuteChecker import mipsPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue,
    input  instrWord    instruction,
    input  logic [31:0] pcPlus4,
    input  logic        commitValid,
    input  logic [4:0]  commitAddress,
    input  logic [31:0] commitData,
    output int          cycleCount,
    output int          commitCount,
    output int          errorCount
);

    logic [31:0] model [32];  // reference register state
    logic        expValid;
    logic [4:0]  expAddress;
    logic [31:0] expData;

    // shift right, then fill vacated top bits with the sign
    function automatic logic [31:0] shiftArith(input logic [31:0] value, input logic [4:0] amount);
        logic [31:0] fill;
        fill = value[31] ? ~(32'hFFFF_FFFF >> amount) : 32'h0;
        return (value >> amount) | fill;
    endfunction

    // signed less-than from the sign bits first
    function automatic logic [31:0] lessSigned(input logic [31:0] a, input logic [31:0] b);
        logic less;
        less = (a[31] != b[31]) ? a[31] : (a < b);
        return {31'd0, less};
    endfunction

    task automatic predictCommit();
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] signImm;
        logic [31:0] zeroImm;
        logic [4:0]  shamt;
        rsVal   = model[instruction.rView.rs];
        rtVal   = model[instruction.rView.rt];
        shamt   = instruction.rView.shamt;
        signImm = {{16{instruction.iView.imm[15]}}, instruction.iView.imm};
        zeroImm = {16'h0000, instruction.iView.imm};
        expValid   = 1'b1;
        expAddress = instruction.iView.rt;  // i-type default
        expData    = 32'h0;
        case (instruction.rView.opcode)
            opSpecial: begin
                expAddress = instruction.rView.rd;
                case (instruction.rView.funct)
                    fnSll:         expData = rtVal << shamt;
                    fnSrl:         expData = rtVal >> shamt;
                    fnSra:         expData = shiftArith(rtVal, shamt);
                    fnSllv:        expData = rtVal << rsVal[4:0];
                    fnSrlv:        expData = rtVal >> rsVal[4:0];
                    fnSrav:        expData = shiftArith(rtVal, rsVal[4:0]);
                    fnJalr:        expData = pcPlus4;  // link into rd
                    fnAdd, fnAddu: expData = rsVal + rtVal;
                    fnSub, fnSubu: expData = rsVal - rtVal;
                    fnAnd:         expData = rsVal & rtVal;
                    fnOr:          expData = rsVal | rtVal;
                    fnXor:         expData = rsVal ^ rtVal;
                    fnNor:         expData = ~(rsVal | rtVal);
                    fnSlt:         expData = lessSigned(rsVal, rtVal);
                    fnSltu:        expData = {31'd0, rsVal < rtVal};
                    default:       expValid = 1'b0;
                endcase
            end
            opRegimm: begin
                expAddress = linkRegister;
                expData    = pcPlus4;
                if (instruction.iView.rt == rtBgezal) expValid = !rsVal[31];
                else if (instruction.iView.rt == rtBltzal) expValid = rsVal[31];
                else expValid = 1'b0;
            end
            opJal: begin
                expAddress = linkRegister;
                expData    = pcPlus4;
            end
            opAddi, opAddiu: expData = rsVal + signImm;
            opSlti:  expData = lessSigned(rsVal, signImm);
            opSltiu: expData = {31'd0, rsVal < signImm};  // sign-extended, unsigned compare
            opAndi:  expData = rsVal & zeroImm;
            opOri:   expData = rsVal | zeroImm;
            opXori:  expData = rsVal ^ zeroImm;
            opLui:   expData = {instruction.iView.imm, 16'h0000};
            default: expValid = 1'b0;  // undefined opcode
        endcase
        if (!issue || expAddress == 5'd0) expValid = 1'b0;  // idle or r0
    endtask

    // mid-cycle, inputs and commit port are settled
    always @(negedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                model[i] = (5'(i) == stackRegister) ? stackResetValue : 32'(i);
            end
        end else begin
            predictCommit();
            cycleCount++;
            if (commitValid !== expValid) begin
                errorCount++;
                $display("[ERROR] %0t: commitValid %b, expected %b, instruction %h",
                         $time, commitValid, expValid, instruction);
            end else if (expValid && (commitAddress !== expAddress || commitData !== expData)) begin
                errorCount++;
                $display("[ERROR] %0t: commit r%0d = %h, expected r%0d = %h, instruction %h",
                         $time, commitAddress, commitData, expAddress, expData, instruction);
            end
            if (expValid) begin
                commitCount++;
                model[expAddress] = expData;  // follow the model, not the DUT
            end
        end
    end

endmodule

// File: verif/decodeExecuteTb.sv
`timescale 1ns/1ps

module decodeExecuteTb import mipsPkg::*; ();

    logic        clock;
    logic        reset;
    logic        issue;
    instrWord    instruction;
    logic [31:0] pcPlus4;
    logic        commitValid;
    logic [4:0]  commitAddress;
    logic [31:0] commitData;
    int          cycleCount;
    int          commitCount;
    int          errorCount;
    int          timeoutCount;
    int          issuedCount;
    int          waitCycles;
    logic [4:0]  lastDest;  // for back-to-back reads

    decodeExecuteTop dut (
        .clock         (clock),
        .reset         (reset),
        .issue         (issue),
        .instruction   (instruction),
        .pcPlus4       (pcPlus4),
        .commitValid   (commitValid),
        .commitAddress (commitAddress),
        .commitData    (commitData)
    );

    decodeExecuteChecker commitChecker (
        .clock         (clock),
        .reset         (reset),
        .issue         (issue),
        .instruction   (instruction),
        .pcPlus4       (pcPlus4),
        .commitValid   (commitValid),
        .commitAddress (commitAddress),
        .commitData    (commitData),
        .cycleCount    (cycleCount),
        .commitCount   (commitCount),
        .errorCount    (errorCount)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;  // 20 ns period
    end

    function automatic logic [5:0] pickFunct(input logic [3:0] sel);
        case (sel)
            4'd0:    return fnSll;
            4'd1:    return fnSrl;
            4'd2:    return fnSra;
            4'd3:    return fnSllv;
            4'd4:    return fnSrlv;
            4'd5:    return fnSrav;
            4'd6:    return fnAdd;
            4'd7:    return fnAddu;
            4'd8:    return fnSub;
            4'd9:    return fnSubu;
            4'd10:   return fnAnd;
            4'd11:   return fnOr;
            4'd12:   return fnXor;
            4'd13:   return fnNor;
            4'd14:   return fnSlt;
            default: return fnSltu;
        endcase
    endfunction

    function automatic logic [5:0] pickImmOpcode(input logic [2:0] sel);
        case (sel)
            3'd1:    return opAddiu;
            3'd2:    return opSlti;
            3'd3:    return opSltiu;
            3'd4:    return opAndi;
            3'd5:    return opOri;
            3'd6:    return opXori;
            default: return opAddi;
        endcase
    endfunction

    task automatic driveNext();
        logic [31:0] bits;
        int unsigned cls;
        bits = $urandom();
        cls  = $urandom_range(0, 99);
        issue       = ($urandom_range(0, 99) < 80);
        instruction = bits;  // random fields, opcode patched below
        if (cls < 40) begin
            instruction.rView.opcode = opSpecial;
            instruction.rView.funct  = pickFunct(4'($urandom_range(0, 15)));
        end else if (cls < 60) begin
            instruction.iView.opcode = pickImmOpcode(3'($urandom_range(0, 7)));
        end else if (cls < 65) begin
            instruction.iView.opcode = opLui;
        end else if (cls < 72) begin
            instruction.iView.opcode = opJal;
        end else if (cls < 79) begin
            instruction.rView.opcode = opSpecial;
            instruction.rView.funct  = fnJalr;
        end else if (cls < 95) begin
            instruction.iView.opcode = opRegimm;
            instruction.iView.rt     = (cls < 87) ? rtBgezal : rtBltzal;
        end else begin
            instruction.iView.opcode = 6'b111111;  // not decoded
        end
        if ($urandom_range(0, 3) == 0) instruction.rView.rs = lastDest;  // reuse last write
        bits    = $urandom();
        pcPlus4 = {bits[31:2], 2'b00};
        if (issue) begin
            if (instruction.rView.opcode == opSpecial) lastDest = instruction.rView.rd;
            else if (cls >= 65 && cls < 95) lastDest = linkRegister;
            else lastDest = instruction.iView.rt;
        end
    endtask

    initial begin
        void'($urandom(32'he109aa5f));
        reset        = 1'b1;
        issue        = 1'b0;
        instruction  = '0;
        pcPlus4      = 32'h0;
        lastDest     = 5'd0;
        timeoutCount = 0;
        issuedCount  = 0;
        repeat (2) @(posedge clock);
        #2 reset = 1'b0;
        waitCycles = 0;
        while (reset && waitCycles < 10) begin
            @(posedge clock);
            waitCycles++;
        end
        if (reset) begin
            $display("reset was still high after 10 cycles");
            $display("Simulation failed");
            $finish;
        end else begin
            waitCycles = 0;
            while (issuedCount < 2000 && waitCycles < 10000) begin
                @(posedge clock);
                #2 driveNext();
                if (issue) issuedCount++;
                waitCycles++;
            end
            if (issuedCount < 2000) begin
                $display("only %0d instructions issued in %0d cycles", issuedCount, waitCycles);
                timeoutCount++;
            end
            @(posedge clock);
            #2 issue = 1'b0;
            repeat (2) @(posedge clock);  // last commit checked at negedge
            $display("checked %0d cycles, %0d commits, %0d errors, %0d timeouts",
                     cycleCount, commitCount, errorCount, timeoutCount);
            if (errorCount == 0 && timeoutCount == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

// File: tb.f
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/operandDecode.sv
hdl/executeUnit.sv
hdl/decodeExecuteTop.sv
verif/decodeExecute_properties.sv
verif/decodeExecuteChecker.sv
verif/decodeExecuteTb.sv

// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -j 0 --top-module decodeExecuteTb -f tb.f -o decodeExecuteSim
	@out="$$(./obj_dir/decodeExecuteSim)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
